//--- test/stim_frames.txt
// First word is the frame count, then one frame per line, all values hex
// thr x0 y0 w h gap sum_s sum_x sum_y  (rectangle value C8, gap 0 means no packet)
7
80 3 2 5 3 1 F 4B 2D
80 0 0 0 0 1 0 0 0
C7 A 5 4 2 1 8 5C 2C
C8 A 5 4 2 1 0 0 0
20 0 0 10 8 1 80 3C0 1C0
20 1 1 2 2 0 4 6 6
20 F 7 1 1 1 1 F 7

//--- src.f
+incdir+test
rtl/cam_pkg.sv
rtl/uart_pkg.sv
rtl/cam_input.sv
rtl/gravity_acc.sv
rtl/report_tx.sv
rtl/uart_tx.sv
rtl/eye_tracker_top.sv
test/tb_eye_tracker.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the eye tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_eye_tracker -Mdir obj_dir || exit 1

sim_out="$(./obj_dir/Vtb_eye_tracker)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "All tests passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- test/tb_uart_rx.svh
// UART receiver model for the eye tracker testbench
// Samples uart_txd mid-bit and checks each packet against the expected queue

`ifndef TB_UART_RX_SVH
`define TB_UART_RX_SVH

localparam int RX_IDLE_LIMIT = 20000;          // Idle line before giving up
localparam int RX_BYTE_LIMIT = 10 * BAUD_DIV;  // Bytes of one packet follow closely

// Start bit search, then 8 data bits LSB first and the stop bit
task automatic receive_byte(input int limit, output byte_t data, output bit ok);
    int waited;
    int i;
    waited = 0;
    data   = '0;
    ok     = 1'b1;
    while (uart_txd === 1'b1 && waited < limit) begin
        @(negedge cclk);
        waited++;
    end
    if (uart_txd === 1'b1) begin
        ok = 1'b0;
    end else begin
        repeat (BAUD_DIV / 2) @(negedge cclk);     // Middle of the start bit
        if (uart_txd !== 1'b0) begin
            other_errs++;
            $display("Start bit on uart_txd ended before mid-bit");
        end
        for (i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge cclk);
            data[i] = uart_txd;
        end
        repeat (BAUD_DIV) @(negedge cclk);
        if (uart_txd !== 1'b1) begin
            other_errs++;
            $display("Stop bit missing on uart_txd");
        end
    end
endtask

task automatic receive_packet(output bit ok);
    byte_t        pkt [PKT_BYTES];
    grav_result_t want;
    bit           pending;
    int           i;
    receive_byte(RX_IDLE_LIMIT, pkt[0], ok);
    if (!ok) begin
        other_errs++;
        $display("Timeout: uart_txd idle for %0d cycles", RX_IDLE_LIMIT);
    end else begin
        pending = (exp_q.size() != 0);
        want    = '0;
        if (pending) begin
            rx_in_packet = 1'b1;
            want         = exp_q.pop_front();
        end else begin
            other_errs++;
            $display("Packet arrived with no frame result pending");
        end
        for (i = 1; i < PKT_BYTES && ok; i++)
            receive_byte(RX_BYTE_LIMIT, pkt[i], ok);
        if (!ok) begin
            other_errs++;
            $display("Timeout: packet byte %0d did not start in time", i - 1);
        end else if (pending) begin
            check_value("sync byte", 32'(pkt[0]), 32'(SYNC_BYTE));
            check_value("sum_s", {8'd0, pkt[1], pkt[2], pkt[3]}, 32'(want.sum_s));
            check_value("sum_x", {pkt[4], pkt[5], pkt[6], pkt[7]}, 32'(want.sum_x));
            check_value("sum_y", {pkt[8], pkt[9], pkt[10], pkt[11]}, 32'(want.sum_y));
        end
        rx_in_packet = 1'b0;
    end
endtask

`endif

//--- test/tb_eye_tracker.sv
`timescale 1ns/1ns
// Testbench for the eye tracker measurement path
// Drives camera frames from the stimulus file and checks the UART result packets

module tb_eye_tracker;
    import cam_pkg::*;
    import uart_pkg::*;

    localparam int   H_ACT       = 16;
    localparam int   V_ACT       = 8;
    localparam int   BAUD_DIV    = 4;
    localparam int   MAX_FRAMES  = 16;
    localparam int   FIELDS      = 9;       // Words per frame in the stimulus file
    localparam int   PKT_TIMEOUT = 2000;
    localparam pix_t BRIGHT      = 8'hC8;

    // One frame description as read from the file
    typedef struct packed {
        pix_t         thr;
        int           x0;
        int           y0;
        int           w;
        int           h;
        logic         gap;      // Wait for the previous packet before starting
        grav_result_t want;
    } frame_t;

    logic         cclk;
    logic         rst_n;
    logic         fval;
    logic         lval;
    logic         dval;
    pix_t         data_l;
    pix_t         data_r;
    pix_t         jp;
    logic         uart_txd;
    logic [31:0]  stim_mem [0:MAX_FRAMES*FIELDS];
    logic [31:0]  lcg_state;
    grav_result_t exp_q[$];     // Packets still to arrive
    logic         rx_in_packet;
    int           value_errs;
    int           other_errs;

    eye_tracker_top #(
        .H_ACT    (H_ACT),
        .V_ACT    (V_ACT),
        .BAUD_DIV (BAUD_DIV)
    ) dut_i (
        .cclk     (cclk),
        .rst_n    (rst_n),
        .fval     (fval),
        .lval     (lval),
        .dval     (dval),
        .data_l   (data_l),
        .data_r   (data_r),
        .jp       (jp),
        .uart_txd (uart_txd)
    );

    always #4 cclk = ~cclk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            value_errs++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic finish_run();
        $display("Error count: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    `include "tb_uart_rx.svh"

    // ----------------------------------------------------------
    // Pixel source
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Noise at or below the threshold, never bright
    function automatic pix_t background_pixel(input pix_t thr);
        int span;
        span      = int'(thr) + 1;
        lcg_state = lcg_next(lcg_state);
        return pix_t'(int'(lcg_state[23:16]) % span);
    endfunction

    function automatic pix_t pixel_at(input int x, input int y, input frame_t fr);
        if (x >= fr.x0 && x < fr.x0 + fr.w && y >= fr.y0 && y < fr.y0 + fr.h)
            return BRIGHT;
        return background_pixel(fr.thr);
    endfunction

    function automatic frame_t frame_from_stim(input int f);
        frame_t fr;
        int     base;
        base          = 1 + f * FIELDS;
        fr.thr        = pix_t'(stim_mem[base]);
        fr.x0         = int'(stim_mem[base + 1]);
        fr.y0         = int'(stim_mem[base + 2]);
        fr.w          = int'(stim_mem[base + 3]);
        fr.h          = int'(stim_mem[base + 4]);
        fr.gap        = stim_mem[base + 5][0];
        fr.want.sum_s = sum_s_t'(stim_mem[base + 6]);
        fr.want.sum_x = sum_xy_t'(stim_mem[base + 7]);
        fr.want.sum_y = sum_xy_t'(stim_mem[base + 8]);
        return fr;
    endfunction

    // ----------------------------------------------------------
    // Camera frame driver
    // ----------------------------------------------------------
    task automatic drive_frame(input frame_t fr);
        int x;
        int y;
        @(posedge cclk);
        #1;
        jp   = fr.thr;
        fval = FVAL_ACTIVE;
        repeat (2) @(posedge cclk);
        for (y = 0; y < V_ACT; y++) begin
            for (x = 0; x < H_ACT; x += 2) begin
                @(posedge cclk);
                #1;
                lval   = LVAL_ACTIVE;
                dval   = DVAL_ACTIVE;
                data_l = pixel_at(x, y, fr);       // Left tap at x
                data_r = pixel_at(x + 1, y, fr);
            end
            @(posedge cclk);
            #1;
            lval   = !LVAL_ACTIVE;
            dval   = !DVAL_ACTIVE;
            data_l = '0;
            data_r = '0;
            repeat (2) @(posedge cclk);         // Line blanking
        end
        @(posedge cclk);
        #1;
        fval = !FVAL_ACTIVE;
        repeat (2) @(posedge cclk);
    endtask

    task automatic wait_for_packets(output bit ok);
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || rx_in_packet) && cycles < PKT_TIMEOUT) begin
            @(negedge cclk);
            cycles++;
        end
        ok = (exp_q.size() == 0 && !rx_in_packet);
        if (!ok) begin
            other_errs++;
            $display("Timeout: result packet not complete within %0d cycles", PKT_TIMEOUT);
        end
    endtask

    // Line must stay idle high for the whole window
    task automatic check_line_idle(input int cycles);
        logic low_seen;
        int   i;
        low_seen = 1'b0;
        for (i = 0; i < cycles; i++) begin
            @(negedge cclk);
            if (uart_txd !== 1'b1)
                low_seen = 1'b1;
        end
        check_value("uart_txd", 32'(!low_seen), 32'd1);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        frame_t fr;
        int     n_frames;
        int     f;
        bit     ok;
        cclk         = 1'b0;
        rst_n        = 1'b0;
        fval         = !FVAL_ACTIVE;
        lval         = !LVAL_ACTIVE;
        dval         = !DVAL_ACTIVE;
        data_l       = '0;
        data_r       = '0;
        jp           = '0;
        lcg_state    = 32'h270a_90c5;
        rx_in_packet = 1'b0;
        value_errs   = 0;
        other_errs   = 0;
        $readmemh("test/stim_frames.txt", stim_mem);
        n_frames = int'(stim_mem[0]);
        if ($isunknown(stim_mem[0]) || n_frames < 1 || n_frames > MAX_FRAMES) begin
            other_errs++;
            $display("Stimulus file missing or frame count out of range");
            n_frames = 0;
        end

        repeat (8) @(posedge cclk);
        #1;
        rst_n = 1'b1;
        check_value("uart_txd", 32'(uart_txd), 32'd1);
        check_line_idle(100);

        ok = 1'b1;
        for (f = 0; f < n_frames && ok; f++) begin
            fr = frame_from_stim(f);
            if (fr.gap)
                wait_for_packets(ok);
            if (ok) begin
                if (fr.gap)
                    exp_q.push_back(fr.want);   // Gapless frames are dropped by the DUT
                drive_frame(fr);
            end
        end
        if (ok)
            wait_for_packets(ok);
        if (ok)
            check_line_idle(200);               // No stray packet at the end
        finish_run();
    end

    // Receiver runs until the line stays idle too long
    initial begin
        bit ok;
        int waited;
        ok     = 1'b1;
        waited = 0;
        while (rst_n !== 1'b1 && waited < 100) begin
            @(negedge cclk);
            waited++;
        end
        while (ok)
            receive_packet(ok);
        finish_run();
    end

endmodule

//--- rtl/eye_tracker_top.sv
`timescale 1ns/1ns
// Eye tracker measurement path
// Camera input, frame gravity sums and UART report, all on cclk

module eye_tracker_top #(
    parameter int H_ACT    = 640,
    parameter int V_ACT    = 480,
    parameter int BAUD_DIV = 27     // cclk cycles per UART bit
) (
    input  logic          cclk,
    input  logic          rst_n,
    input  logic          fval,
    input  logic          lval,
    input  logic          dval,
    input  cam_pkg::pix_t data_l,
    input  cam_pkg::pix_t data_r,
    input  cam_pkg::pix_t jp,         // Threshold jumpers
    output logic          uart_txd
);
    import cam_pkg::*;
    import uart_pkg::*;

    cam_bus_t     beat;
    grav_result_t res;
    logic         res_req;
    logic         res_ack;
    byte_t        tx_byte;
    logic         tx_start;
    logic         tx_busy;

    // ----------------------------------------------------------
    // Camera side
    // ----------------------------------------------------------
    cam_input #(
        .H_ACT (H_ACT),
        .V_ACT (V_ACT)
    ) cam_input_i (
        .cclk   (cclk),
        .rst_n  (rst_n),
        .fval   (fval),
        .lval   (lval),
        .dval   (dval),
        .data_l (data_l),
        .data_r (data_r),
        .beat   (beat)
    );

    gravity_acc gravity_acc_i (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .beat      (beat),
        .threshold (jp),
        .res       (res),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

    // ----------------------------------------------------------
    // Report side
    // ----------------------------------------------------------
    report_tx report_tx_i (
        .cclk     (cclk),
        .rst_n    (rst_n),
        .res      (res),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) uart_tx_i (
        .cclk     (cclk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd)
    );

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ns
// 8N1 UART transmitter
// Start bit, 8 data bits LSB first, one stop bit, BAUD_DIV clocks per bit

module uart_tx #(
    parameter int BAUD_DIV = 27
) (
    input  logic            cclk,
    input  logic            rst_n,
    input  uart_pkg::byte_t tx_byte,
    input  logic            tx_start,
    output logic            tx_busy,
    output logic            uart_txd
);
    import uart_pkg::*;

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] baud_cnt;
    logic             bit_end;     // Last clock of the current bit
    logic [2:0]       bit_idx;
    byte_t            shreg;

    assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));
    assign tx_busy = (state != TX_IDLE);

    // ----------------------------------------------------------
    // Bit timing and line state
    // ----------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_txd <= 1'b1;      // Line idles high
        end else begin
            if (state == TX_IDLE || bit_end)
                baud_cnt <= '0;
            else
                baud_cnt <= baud_cnt + 1'b1;

            case (state)
                TX_IDLE: if (tx_start) begin
                    uart_txd <= 1'b0;
                    state    <= TX_START;
                end
                TX_START: if (bit_end) begin
                    uart_txd <= shreg[0];
                    bit_idx  <= '0;
                    state    <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        uart_txd <= 1'b1;    // Stop bit
                        state    <= TX_STOP;
                    end else begin
                        uart_txd <= shreg[1];
                        bit_idx  <= bit_idx + 1'b1;
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Data shifter
    always_ff @(posedge cclk) begin
        if (state == TX_IDLE && tx_start)
            shreg <= tx_byte;
        else if (state == TX_DATA && bit_end)
            shreg <= shreg >> 1;
    end

    // The reporter must wait for the line to go idle
    a_no_start_busy : assert property (@(posedge cclk) disable iff (!rst_n)
        tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while busy");

endmodule

//--- rtl/report_tx.sv
`timescale 1ns/1ns
// Result reporter
// Latches a gravity result and streams it as a 12-byte packet to the UART

module report_tx (
    input  logic                   cclk,
    input  logic                   rst_n,
    input  uart_pkg::grav_result_t res,
    input  logic                   res_req,
    output logic                   res_ack,
    output uart_pkg::byte_t        tx_byte,
    output logic                   tx_start,
    input  logic                   tx_busy
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(PKT_BYTES);

    typedef enum logic [2:0] {
        REP_IDLE,
        REP_LOAD,       // Pick the next byte
        REP_SEND,       // Wait for an idle UART and start it
        REP_WAIT,       // Byte on the line
        REP_DONE        // Packet out, close the handshake
    } rep_state_t;

    rep_state_t             state;
    grav_result_t           res_q;
    logic [IDX_W-1:0]       byte_idx;
    logic [PKT_BYTES*8-1:0] pkt;
    logic                   last_byte;

    // Whole packet, sync byte in the top bits
    assign pkt = {SYNC_BYTE, 24'(res_q.sum_s), 32'(res_q.sum_x), 32'(res_q.sum_y)};

    assign last_byte = (byte_idx == IDX_W'(PKT_BYTES - 1));
    assign tx_start  = (state == REP_SEND) && !tx_busy;

    // ----------------------------------------------------------
    // Packet sequencer
    // ----------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= REP_IDLE;
            res_ack  <= 1'b0;
            byte_idx <= '0;
        end else begin
            case (state)
                REP_IDLE: if (res_req) begin
                    res_ack  <= 1'b1;   // Held for the whole packet
                    byte_idx <= '0;
                    state    <= REP_LOAD;
                end
                REP_LOAD: state <= REP_SEND;
                REP_SEND: if (!tx_busy) state <= REP_WAIT;
                REP_WAIT: if (!tx_busy) begin
                    if (last_byte) begin
                        state <= REP_DONE;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                        state    <= REP_LOAD;
                    end
                end
                REP_DONE: if (!res_req) begin
                    res_ack <= 1'b0;
                    state   <= REP_IDLE;
                end
                default: state <= REP_IDLE;
            endcase
        end
    end

    // Result copy and byte select
    always_ff @(posedge cclk) begin
        if (state == REP_IDLE && res_req)
            res_q <= res;
        if (state == REP_LOAD)
            tx_byte <= pkt[(PKT_BYTES - 1 - int'(byte_idx)) * 8 +: 8];
    end

endmodule

//--- rtl/gravity_acc.sv
`timescale 1ns/1ns
// Gravity accumulator
// Thresholds both taps, sums count, x and y over a frame, hands result by req/ack

module gravity_acc (
    input  logic                   cclk,
    input  logic                   rst_n,
    input  cam_pkg::cam_bus_t      beat,
    input  cam_pkg::pix_t          threshold,
    output uart_pkg::grav_result_t res,
    output logic                   res_req,
    input  logic                   res_ack
);
    import cam_pkg::*;

    sum_s_t  acc_s;
    sum_xy_t acc_x;
    sum_xy_t acc_y;
    logic    bright_l;
    logic    bright_r;
    sum_xy_t x_l;
    sum_xy_t x_r;
    sum_xy_t y_w;
    sum_s_t  inc_s;
    sum_xy_t inc_x;
    sum_xy_t inc_y;
    logic    hs_open;      // Previous result still in flight
    logic    take;         // Publish this frame

    // ----------------------------------------------------------
    // Binarize and form the per-beat increments
    // ----------------------------------------------------------
    // Equal to threshold counts as dark
    assign bright_l = beat.de && (beat.data_l > threshold);
    assign bright_r = beat.de && (beat.data_r > threshold);

    assign x_l = sum_xy_t'(beat.x);
    assign x_r = x_l + sum_xy_t'(1);     // Right tap is one column over
    assign y_w = sum_xy_t'(beat.y);

    always_comb begin
        inc_s = sum_s_t'(bright_l) + sum_s_t'(bright_r);
        inc_x = (bright_l ? x_l : '0) + (bright_r ? x_r : '0);
        inc_y = (bright_l ? y_w : '0) + (bright_r ? y_w : '0);
    end

    assign hs_open = res_req || res_ack;
    assign take    = beat.frame_end && !hs_open;

    // ----------------------------------------------------------
    // Frame accumulators and request
    // ----------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_s   <= '0;
            acc_x   <= '0;
            acc_y   <= '0;
            res_req <= 1'b0;
        end else begin
            if (beat.frame_end) begin
                // Cleared even when the result is dropped
                acc_s <= '0;
                acc_x <= '0;
                acc_y <= '0;
            end else begin
                acc_s <= acc_s + inc_s;
                acc_x <= acc_x + inc_x;
                acc_y <= acc_y + inc_y;
            end

            if (take)
                res_req <= 1'b1;
            else if (res_ack)
                res_req <= 1'b0;        // Reporter has its copy
        end
    end

    // Result snapshot
    always_ff @(posedge cclk) begin
        if (take) begin
            res.sum_s <= acc_s;
            res.sum_x <= acc_x;
            res.sum_y <= acc_y;
        end
    end

    // Handshake rules seen from the producer side
    a_res_stable : assert property (@(posedge cclk) disable iff (!rst_n)
        res_req |=> (!res_req || $stable(res)))
        else $error("gravity_acc: res changed during request");

    a_req_after_ack : assert property (@(posedge cclk) disable iff (!rst_n)
        $fell(res_req) |-> $past(res_ack))
        else $error("gravity_acc: res_req dropped without res_ack");

endmodule

//--- rtl/cam_input.sv
`timescale 1ns/1ns
// Camera Link input stage
// Registers the two-tap stream, normalizes polarity and tracks pixel position

module cam_input #(
    parameter int H_ACT = 640,
    parameter int V_ACT = 480
) (
    input  logic              cclk,
    input  logic              rst_n,
    input  logic              fval,
    input  logic              lval,
    input  logic              dval,
    input  cam_pkg::pix_t     data_l,
    input  cam_pkg::pix_t     data_r,
    output cam_pkg::cam_bus_t beat
);
    import cam_pkg::*;

    logic   fval_a;
    logic   lval_a;
    logic   dval_a;
    logic   fval_q;         // Previous frame level for the falling edge
    logic   lval_q;         // Previous line level
    coord_t x_cnt;          // Column of the left tap of the next beat
    coord_t y_cnt;          // Current line inside the frame
    logic   pix_valid;
    logic   in_window;

    // Active-high versions of the valid lines
    assign fval_a = (fval == FVAL_ACTIVE);
    assign lval_a = (lval == LVAL_ACTIVE);
    assign dval_a = (dval == DVAL_ACTIVE);

    assign pix_valid = fval_a && lval_a && dval_a;
    assign in_window = (x_cnt < H_ACT) && (y_cnt < V_ACT);

    // ----------------------------------------------------------
    // Position counters and output register
    // ----------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            fval_q <= 1'b0;
            lval_q <= 1'b0;
            x_cnt  <= '0;
            y_cnt  <= '0;
            beat   <= '0;
        end else begin
            fval_q <= fval_a;
            lval_q <= lval_a;

            // Two pixels per beat
            if (!lval_a)
                x_cnt <= '0;
            else if (pix_valid)
                x_cnt <= x_cnt + coord_t'(2);

            if (!fval_a)
                y_cnt <= '0;            // Next frame starts at line 0
            else if (lval_q && !lval_a)
                y_cnt <= y_cnt + coord_t'(1);

            beat.de        <= pix_valid && in_window;
            beat.frame_end <= fval_q && !fval_a;
            beat.x         <= x_cnt;
            beat.y         <= y_cnt;
            beat.data_l    <= data_l;
            beat.data_r    <= data_r;
        end
    end

    // Right tap of an enabled beat still inside the active line
    a_x_in_line : assert property (@(posedge cclk) disable iff (!rst_n)
        beat.de |-> (int'(beat.x) + 1 < H_ACT))
        else $error("cam_input: de with right tap x=%0d beyond H_ACT", int'(beat.x) + 1);

endmodule

//--- rtl/uart_pkg.sv
// Report-side definitions for the eye tracker
// UART byte type and the layout of the gravity result packet

package uart_pkg;

    typedef logic [7:0] byte_t;

    // ----------------------------------------------------------
    // Result packet
    // ----------------------------------------------------------
    // Byte order on the line, each sum MSB first
    //   A5 | sum_s (3 bytes) | sum_x (4 bytes) | sum_y (4 bytes)
    localparam int    PKT_BYTES = 12;
    localparam byte_t SYNC_BYTE = 8'hA5;   // Lead byte for receiver alignment

    // Frame result handed from the gravity block to the reporter
    typedef struct packed {
        cam_pkg::sum_s_t  sum_s;    // Number of bright pixels
        cam_pkg::sum_xy_t sum_x;    // Sum of their x positions
        cam_pkg::sum_xy_t sum_y;    // Sum of their y positions
    } grav_result_t;

    // Centre of gravity on the host side is sum_x / sum_s and sum_y / sum_s

endpackage

//--- rtl/cam_pkg.sv
// Camera-side definitions for the eye tracker
// Pixel, coordinate and sum widths plus the Camera Link sync polarities

package cam_pkg;

    // ----------------------------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------------------------
    typedef logic [7:0]  pix_t;     // Pixel or threshold value
    typedef logic [9:0]  coord_t;   // x or y position
    typedef logic [19:0] sum_s_t;   // Bright pixel count per frame
    typedef logic [27:0] sum_xy_t;  // Coordinate sum per frame

    // Active levels of the camera valid lines
    localparam logic FVAL_ACTIVE = 1'b1;
    localparam logic LVAL_ACTIVE = 1'b1;
    localparam logic DVAL_ACTIVE = 1'b0;   // Camera drives dval low during data

    // One registered camera beat, both taps at once
    // data_l sits at x, data_r at x+1
    typedef struct packed {
        logic   de;         // Beat inside the active window
        logic   frame_end;  // Single pulse after fval drops
        coord_t x;
        coord_t y;
        pix_t   data_l;
        pix_t   data_r;
    } cam_bus_t;

endpackage
